/* hw/dual_issue.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dual-issue steering
// Pipe and target hazard check, split-pair FSM and the
// even/odd issue registers
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dual_issue (
    input  logic              clk,
    input  logic              rst,
    input  spu_pkg::decoded_t slot1_dec,
    input  spu_pkg::decoded_t slot2_dec,
    output logic              stall,
    output spu_pkg::issue_t   even_issue,
    output spu_pkg::issue_t   odd_issue
);
    import spu_pkg::*;

    issue_state_e state;
    logic         pipe_clash;
    logic         rt_clash;
    decoded_t     single;
    issue_t       even_next;
    issue_t       odd_next;

    assign pipe_clash = (slot1_dec.pipe == slot2_dec.pipe);
    assign rt_clash   = slot1_dec.rt_valid && slot2_dec.rt_valid &&
                        (slot1_dec.issue.rt == slot2_dec.issue.rt);

    // Second half of a split pair never stalls again
    assign stall = (state == ISSUE_PAIR) && (pipe_clash || rt_clash);

    // Record that goes out alone on a split
    assign single = (state == ISSUE_SECOND) ? slot2_dec : slot1_dec;

    always_comb
    begin
        if (stall || state == ISSUE_SECOND)
        begin
            even_next = (single.pipe == PIPE_EVEN) ? single.issue : EVEN_IDLE;
            odd_next  = (single.pipe == PIPE_ODD) ? single.issue : ODD_IDLE;
        end
        else if (slot1_dec.pipe == PIPE_EVEN)
        begin
            even_next = slot1_dec.issue;
            odd_next  = slot2_dec.issue;
        end
        else
        begin
            // Pipes differ here, so slot 2 is the even one
            even_next = slot2_dec.issue;
            odd_next  = slot1_dec.issue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ISSUE_PAIR;
            even_issue <= EVEN_IDLE;
            odd_issue  <= ODD_IDLE;
        end
        else
        begin
            even_issue <= even_next;
            odd_issue  <= odd_next;
            if (stall)
            begin
                state <= ISSUE_SECOND;
            end
            else
            begin
                state <= ISSUE_PAIR;
            end
        end
    end

endmodule

/* hw/instr_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction decoder for one issue slot
// Matches RRR, RI18 and RI10 formats, the fill marker and
// unknown words into a decoded record with target pipe
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module instr_decoder #(
    parameter bit is_first_slot = 1'b1
) (
    input  spu_pkg::instr_t   instr,
    output spu_pkg::decoded_t dec
);
    import spu_pkg::*;

    logic [0:3] major4;
    logic [0:6] major7;
    logic [0:7] major8;

    logic       rrr_hit;
    opcode_e    rrr_op;
    logic       ri10_hit;
    opcode_e    ri10_op;

    assign major4 = instr[0:3];
    assign major7 = instr[0:6];
    assign major8 = instr[0:7];

    // Format tables
    always_comb
    begin
        rrr_hit = 1'b1;
        rrr_op  = OP_NOP;
        case (major4)
            4'b1100: rrr_op = OP_MPYA;
            4'b1110: rrr_op = OP_FMA;
            4'b1111: rrr_op = OP_FMS;
            default: rrr_hit = 1'b0;
        endcase

        ri10_hit = 1'b1;
        ri10_op  = OP_NOP;
        case (major8)
            8'b00011101: ri10_op = OP_AHI;
            8'b00011100: ri10_op = OP_AI;
            8'b00001101: ri10_op = OP_SFHI;
            8'b00001100: ri10_op = OP_SFI;
            8'b01110100: ri10_op = OP_MPYI;
            8'b00010100: ri10_op = OP_ANDI;
            8'b00010101: ri10_op = OP_ANDHI;
            8'b00010110: ri10_op = OP_ANDBI;
            8'b00000100: ri10_op = OP_ORI;
            8'b00000101: ri10_op = OP_ORHI;
            8'b00000110: ri10_op = OP_ORBI;
            8'b01000100: ri10_op = OP_XORI;
            8'b01000101: ri10_op = OP_XORHI;
            8'b01000110: ri10_op = OP_XORBI;
            8'b01111100: ri10_op = OP_CEQI;
            8'b01111110: ri10_op = OP_CEQHI;
            8'b01001100: ri10_op = OP_CGTI;
            8'b01001101: ri10_op = OP_CGTHI;
            8'b00110100: ri10_op = OP_LQD;
            8'b00100100: ri10_op = OP_STQD;
            default:     ri10_hit = 1'b0;
        endcase
    end

    always_comb
    begin
        // Slot's own no-op unless a format matches
        dec.issue    = is_first_slot ? EVEN_IDLE : ODD_IDLE;
        dec.pipe     = is_first_slot ? PIPE_EVEN : PIPE_ODD;
        dec.rt_valid = 1'b0;

        // All ones would also hit the RRR table, so test it first
        if (instr == FILL_MARKER)
        begin
            if (is_first_slot)
            begin
                dec.issue.opcode = OP_CMISS;
                dec.pipe         = PIPE_ODD;
            end
            else
            begin
                dec.issue = EVEN_IDLE;
                dec.pipe  = PIPE_EVEN;
            end
        end
        else if (rrr_hit)
        begin
            dec.issue.opcode = rrr_op;
            dec.issue.rt     = instr[4:10];
            dec.issue.ra     = instr[11:17];
            dec.issue.rb     = instr[18:24];
            dec.issue.rc     = instr[25:31];
            dec.pipe         = PIPE_EVEN;
            dec.rt_valid     = 1'b1;
        end
        else if (major7 == 7'b0100001)
        begin
            dec.issue.opcode = OP_ILA;
            dec.issue.imm18  = instr[7:24];
            dec.issue.rt     = instr[25:31];
            dec.pipe         = PIPE_EVEN;
            dec.rt_valid     = 1'b1;
        end
        else if (ri10_hit)
        begin
            dec.issue.opcode = ri10_op;
            dec.issue.imm10  = instr[8:17];
            dec.issue.ra     = instr[18:24];
            dec.issue.rt     = instr[25:31];
            dec.pipe         = (ri10_op == OP_LQD || ri10_op == OP_STQD) ? PIPE_ODD : PIPE_EVEN;
            dec.rt_valid     = 1'b1;
            // Store reads its rt field as data source, no write back
            if (ri10_op == OP_STQD)
            begin
                dec.issue.rc = instr[25:31];
                dec.rt_valid = 1'b0;
            end
        end
    end

endmodule

/* hw/spu_decode_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Decode stage top level
// Two slot decoders feeding the dual-issue unit
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spu_decode_top (
    input  logic            clk,
    input  logic            rst,
    input  spu_pkg::instr_t eins1,
    input  spu_pkg::instr_t eins2,
    output logic            stall,
    output spu_pkg::issue_t even_issue,
    output spu_pkg::issue_t odd_issue
);
    import spu_pkg::*;

    decoded_t slot1_dec;
    decoded_t slot2_dec;

    instr_decoder #(
        .is_first_slot(1'b1)
    ) u_dec1 (
        .instr(eins1),
        .dec  (slot1_dec)
    );

    instr_decoder #(
        .is_first_slot(1'b0)
    ) u_dec2 (
        .instr(eins2),
        .dec  (slot2_dec)
    );

    dual_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .slot1_dec (slot1_dec),
        .slot2_dec (slot2_dec),
        .stall     (stall),
        .even_issue(even_issue),
        .odd_issue (odd_issue)
    );

endmodule

/* hw/spu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the dual-issue decode stage:
// widths, instruction and field types, opcode and pipe enums,
// decoded and issue records, issue FSM states and idle records
// ~~~~~~~~~~~~~~~~~~~~

package spu_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 7;
    localparam int IMM10_W    = 10;
    localparam int IMM18_W    = 18;

    // Bit 0 is the most significant bit, as in the ISA manual
    typedef logic [0:INSTR_W-1]    instr_t;
    typedef logic [0:REG_ADDR_W-1] reg_addr_t;
    typedef logic [0:IMM10_W-1]    imm10_t;
    typedef logic [0:IMM18_W-1]    imm18_t;

    // Cache-miss fill word from the instruction fetch
    localparam instr_t FILL_MARKER = 32'hffff_ffff;

    typedef enum logic [5:0] {
        // No-ops and fill marker
        OP_NOP,
        OP_LNOP,
        OP_CMISS,
        // RRR
        OP_MPYA,
        OP_FMA,
        OP_FMS,
        // RI18
        OP_ILA,
        // RI10 arithmetic
        OP_AHI,
        OP_AI,
        OP_SFHI,
        OP_SFI,
        OP_MPYI,
        // RI10 logical
        OP_ANDI,
        OP_ANDHI,
        OP_ANDBI,
        OP_ORI,
        OP_ORHI,
        OP_ORBI,
        OP_XORI,
        OP_XORHI,
        OP_XORBI,
        // RI10 compare
        OP_CEQI,
        OP_CEQHI,
        OP_CGTI,
        OP_CGTHI,
        // RI10 quadword load/store, odd pipe
        OP_LQD,
        OP_STQD
    } opcode_e;

    typedef enum logic {
        PIPE_EVEN = 1'b0,
        PIPE_ODD  = 1'b1
    } pipe_e;

    // What one pipe receives
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rt;
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rc;
        imm10_t    imm10;
        imm18_t    imm18;
    } issue_t;

    // One decoded slot
    typedef struct packed {
        issue_t issue;
        pipe_e  pipe;
        logic   rt_valid;
    } decoded_t;

    typedef enum logic {
        ISSUE_PAIR   = 1'b0,
        ISSUE_SECOND = 1'b1
    } issue_state_e;

    localparam issue_t EVEN_IDLE = '{
        opcode: OP_NOP,
        rt:     '0,
        ra:     '0,
        rb:     '0,
        rc:     '0,
        imm10:  '0,
        imm18:  '0
    };

    localparam issue_t ODD_IDLE = '{
        opcode: OP_LNOP,
        rt:     '0,
        ra:     '0,
        rb:     '0,
        rc:     '0,
        imm10:  '0,
        imm18:  '0
    };

endpackage

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_spu_decode \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log
grep -q "TEST PASSED" sim.log
echo "Simulation finished without failures"

/* testbench/spu_decode_props.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Bound properties for the decode stage
// Reset values, single-cycle stall, idle pipe on split pairs
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spu_decode_props (
    input logic            clk,
    input logic            rst,
    input spu_pkg::instr_t eins1,
    input spu_pkg::instr_t eins2,
    input logic            stall,
    input spu_pkg::issue_t even_issue,
    input spu_pkg::issue_t odd_issue
);
    import spu_pkg::*;

    logic one_idle;

    assign one_idle = (even_issue == EVEN_IDLE) || (odd_issue == ODD_IDLE);

    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> (even_issue == EVEN_IDLE) && (odd_issue == ODD_IDLE))
        else $error("issue registers not idle after reset");

    // Zero words decode to each slot's own no-op
    reset_no_stall: assert property (@(posedge clk)
        $fell(rst) && (eins1 == '0) && (eins2 == '0) |-> !stall)
        else $error("stall high right after reset with no-op inputs");

    no_double_stall: assert property (@(posedge clk) disable iff (rst)
        $past(stall) |-> !stall)
        else $error("stall high on two consecutive cycles");

    split_first_idle: assert property (@(posedge clk) disable iff (rst)
        $past(stall) |-> one_idle)
        else $error("first half of a split pair left no pipe idle");

    split_second_idle: assert property (@(posedge clk) disable iff (rst)
        $past(stall, 2) |-> one_idle)
        else $error("second half of a split pair left no pipe idle");

endmodule

bind spu_decode_top spu_decode_props u_props (
    .clk       (clk),
    .rst       (rst),
    .eins1     (eins1),
    .eins2     (eins2),
    .stall     (stall),
    .even_issue(even_issue),
    .odd_issue (odd_issue)
);

/* testbench/tb_spu_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the decode stage top level
// Clock, reset, directed and random pairs, reference decode,
// expected-issue queue, output assertions and timeout
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_spu_decode;
    import spu_pkg::*;

    localparam int N_OPS       = 24;
    localparam int N_KINDS     = 26;
    localparam int IDX_AHI     = 4;
    localparam int IDX_AI      = 5;
    localparam int IDX_LQD     = 22;
    localparam int IDX_STQD    = 23;
    localparam int IDX_MARKER  = 24;
    localparam int IDX_UNKNOWN = 25;
    localparam int N_DIRECTED  = 16;
    localparam int N_RANDOM    = 210;
    // Two cycles per pair at most, doubled for margin
    localparam int MAX_CYCLES  = 4 * (N_DIRECTED + N_OPS + N_RANDOM);

    localparam logic [1:0] FMT_RRR  = 2'd0;
    localparam logic [1:0] FMT_RI18 = 2'd1;
    localparam logic [1:0] FMT_RI10 = 2'd2;

    // Major codes left-aligned in a byte, same order as OP_LIST
    localparam opcode_e OP_LIST [N_OPS] = '{
        OP_MPYA, OP_FMA, OP_FMS, OP_ILA, OP_AHI, OP_AI, OP_SFHI, OP_SFI,
        OP_MPYI, OP_ANDI, OP_ANDHI, OP_ANDBI, OP_ORI, OP_ORHI, OP_ORBI,
        OP_XORI, OP_XORHI, OP_XORBI, OP_CEQI, OP_CEQHI, OP_CGTI, OP_CGTHI,
        OP_LQD, OP_STQD
    };
    localparam logic [7:0] CODE_LIST [N_OPS] = '{
        8'hc0, 8'he0, 8'hf0, 8'h42, 8'h1d, 8'h1c, 8'h0d, 8'h0c,
        8'h74, 8'h14, 8'h15, 8'h16, 8'h04, 8'h05, 8'h06,
        8'h44, 8'h45, 8'h46, 8'h7c, 8'h7e, 8'h4c, 8'h4d,
        8'h34, 8'h24
    };

    typedef struct packed {
        issue_t even;
        issue_t odd;
    } lane_pair_t;

    logic     clk;
    logic     rst;
    instr_t   eins1;
    instr_t   eins2;
    logic     stall;
    issue_t   even_issue;
    issue_t   odd_issue;

    int         seed;
    int         cycles;
    decoded_t   ref1;
    decoded_t   ref2;
    issue_t     exp_even;
    issue_t     exp_odd;
    logic       exp_stall;
    logic       model_second;
    lane_pair_t pending[$];

    spu_decode_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .eins1     (eins1),
        .eins2     (eins2),
        .stall     (stall),
        .even_issue(even_issue),
        .odd_issue (odd_issue)
    );

    function automatic logic [1:0] fmt_of(input int idx);
        if (idx < 3)
            return FMT_RRR;
        else if (idx == 3)
            return FMT_RI18;
        return FMT_RI10;
    endfunction

    function automatic int prefix_len(input logic [1:0] fmt);
        return (fmt == FMT_RRR) ? 4 : (fmt == FMT_RI18) ? 7 : 8;
    endfunction

    // Bits counted from the MSB as bit 0
    function automatic logic [31:0] field(input logic [31:0] v, input int start, input int len);
        return (v >> (32 - start - len)) & ((32'd1 << len) - 32'd1);
    endfunction

    function automatic decoded_t ref_decode(input instr_t w, input bit first);
        decoded_t    d;
        logic [31:0] v;
        int          len;
        int          hit;
        v   = w;
        hit = -1;
        for (int i = 0; i < N_OPS; i++)
        begin
            len = prefix_len(fmt_of(i));
            if (hit < 0 && (v[31:24] >> (8 - len)) == (CODE_LIST[i] >> (8 - len)))
                hit = i;
        end
        d.issue    = first ? EVEN_IDLE : ODD_IDLE;
        d.pipe     = first ? PIPE_EVEN : PIPE_ODD;
        d.rt_valid = 1'b0;
        if (v == 32'hffff_ffff)
        begin
            d.issue        = EVEN_IDLE;
            d.pipe         = first ? PIPE_ODD : PIPE_EVEN;
            d.issue.opcode = first ? OP_CMISS : OP_NOP;
        end
        else if (hit >= 0)
        begin
            d.issue.opcode = OP_LIST[hit];
            d.issue.rt     = reg_addr_t'(field(v, 25, 7));
            d.pipe         = PIPE_EVEN;
            d.rt_valid     = 1'b1;
            case (fmt_of(hit))
                FMT_RRR:
                begin
                    d.issue.rt = reg_addr_t'(field(v, 4, 7));
                    d.issue.ra = reg_addr_t'(field(v, 11, 7));
                    d.issue.rb = reg_addr_t'(field(v, 18, 7));
                    d.issue.rc = reg_addr_t'(field(v, 25, 7));
                end
                FMT_RI18:
                    d.issue.imm18 = imm18_t'(field(v, 7, 18));
                default:
                begin
                    d.issue.imm10 = imm10_t'(field(v, 8, 10));
                    d.issue.ra    = reg_addr_t'(field(v, 18, 7));
                    if (hit == IDX_LQD || hit == IDX_STQD)
                        d.pipe = PIPE_ODD;
                    // Store data register comes from the rt field
                    if (hit == IDX_STQD)
                    begin
                        d.issue.rc = reg_addr_t'(field(v, 25, 7));
                        d.rt_valid = 1'b0;
                    end
                end
            endcase
        end
        return d;
    endfunction

    function automatic bit pair_hazard(input decoded_t d1, input decoded_t d2);
        return (d1.pipe == d2.pipe) ||
               (d1.rt_valid && d2.rt_valid && d1.issue.rt == d2.issue.rt);
    endfunction

    function automatic lane_pair_t steer_one(input decoded_t d);
        lane_pair_t p;
        p.even = (d.pipe == PIPE_EVEN) ? d.issue : EVEN_IDLE;
        p.odd  = (d.pipe == PIPE_ODD) ? d.issue : ODD_IDLE;
        return p;
    endfunction

    function automatic lane_pair_t steer_both(input decoded_t d1, input decoded_t d2);
        lane_pair_t p;
        p.even = (d1.pipe == PIPE_EVEN) ? d1.issue : d2.issue;
        p.odd  = (d1.pipe == PIPE_EVEN) ? d2.issue : d1.issue;
        return p;
    endfunction

    function automatic logic [31:0] rand_word();
        return {$random(seed)};
    endfunction

    function automatic int rand_index();
        return int'({$random(seed)} % N_KINDS);
    endfunction

    // Major code kept, all lower bits random
    function automatic instr_t make_word(input int idx, input logic [31:0] r);
        logic [31:0] mask;
        logic [31:0] v;
        if (idx == IDX_MARKER)
            v = 32'hffff_ffff;
        else if (idx == IDX_UNKNOWN)
            v = {r[31] ? 8'h80 : 8'h00, r[23:0]};
        else
        begin
            mask = 32'hffff_ffff >> prefix_len(fmt_of(idx));
            v    = ({CODE_LIST[idx], 24'h0} & ~mask) | (r & mask);
        end
        return v;
    endfunction

    function automatic instr_t with_rt(input instr_t w, input logic [6:0] rt);
        logic [31:0] v;
        v      = w;
        v[6:0] = rt;
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERROR: %s expected %h actual %h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "output mismatch");
    endtask

    // Called just after a rising edge; holds the pair through a stall
    task automatic send_pair(input instr_t a, input instr_t b);
        eins1 <= a;
        eins2 <= b;
        @(posedge clk);
        if (stall)
            @(posedge clk);
    endtask

    assign ref1      = ref_decode(eins1, 1'b1);
    assign ref2      = ref_decode(eins2, 1'b0);
    assign exp_stall = !model_second && pair_hazard(ref1, ref2);

    // Reference issue model, one queue entry per issue cycle
    always @(posedge clk)
    begin
        lane_pair_t next_out;
        if (rst)
        begin
            pending.delete();
            exp_even     <= EVEN_IDLE;
            exp_odd      <= ODD_IDLE;
            model_second <= 1'b0;
        end
        else
        begin
            if (pending.size() == 0)
            begin
                if (pair_hazard(ref1, ref2))
                begin
                    pending.push_back(steer_one(ref1));
                    pending.push_back(steer_one(ref2));
                end
                else
                    pending.push_back(steer_both(ref1, ref2));
            end
            next_out = pending.pop_front();
            exp_even     <= next_out.even;
            exp_odd      <= next_out.odd;
            model_second <= (pending.size() != 0);
        end
    end

    even_check: assert property (@(negedge clk) disable iff (rst) even_issue == exp_even)
        else report_mismatch("even_issue", 64'(exp_even), 64'(even_issue));
    odd_check: assert property (@(negedge clk) disable iff (rst) odd_issue == exp_odd)
        else report_mismatch("odd_issue", 64'(exp_odd), 64'(odd_issue));
    stall_check: assert property (@(negedge clk) disable iff (rst) stall == exp_stall)
        else report_mismatch("stall", 64'(exp_stall), 64'(stall));

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYCLES)
            begin
                $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial
    begin
        instr_t ai_w;
        instr_t ahi_w;
        instr_t lqd_w;
        instr_t stqd_w;
        instr_t unk_w;

        rst   = 1'b1;
        eins1 = '0;
        eins2 = '0;
        seed  = 32'hc690;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // One cycle of no-op words after reset
        @(posedge clk);

        ai_w   = with_rt(make_word(IDX_AI, rand_word()), 7'd5);
        ahi_w  = with_rt(make_word(IDX_AHI, rand_word()), 7'd6);
        lqd_w  = with_rt(make_word(IDX_LQD, rand_word()), 7'd9);
        stqd_w = with_rt(make_word(IDX_STQD, rand_word()), 7'd5);
        unk_w  = make_word(IDX_UNKNOWN, rand_word());

        // Complementary pairs, even record in either slot
        send_pair(ai_w, lqd_w);
        send_pair(lqd_w, ai_w);
        // Same pipe
        send_pair(ai_w, ahi_w);
        send_pair(lqd_w, stqd_w);
        // Equal targets across pipes, store has no write
        send_pair(ai_w, with_rt(lqd_w, 7'd5));
        send_pair(ai_w, stqd_w);
        // Fill marker and unknown words
        send_pair(FILL_MARKER, ai_w);
        send_pair(ai_w, FILL_MARKER);
        send_pair(FILL_MARKER, FILL_MARKER);
        send_pair(unk_w, unk_w);
        send_pair(unk_w, lqd_w);
        send_pair(ai_w, unk_w);

        // Every opcode at least once in slot 1
        for (int i = 0; i < N_OPS; i++)
            send_pair(make_word(i, rand_word()), make_word(rand_index(), rand_word()));

        for (int i = 0; i < N_RANDOM; i++)
            send_pair(make_word(rand_index(), rand_word()), make_word(rand_index(), rand_word()));

        eins1 <= '0;
        eins2 <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog.f */
hw/spu_pkg.sv
hw/instr_decoder.sv
hw/dual_issue.sv
hw/spu_decode_top.sv
testbench/spu_decode_props.sv
testbench/tb_spu_decode.sv
